/* design/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// number of reorder buffer entries, a power of two
`define ROB_DEPTH 8

// entry index width, log2 of the depth
`define ROB_TAG_W 3

// data and address word width
`define XLEN 32

`endif

/* design/rv32_pkg.sv */
`default_nettype none

`include "rob_defines.svh"

package rv32_pkg;

    // data or address word
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // store access size, sb / sh / sw
    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } store_width_t;

endpackage : rv32_pkg

`default_nettype wire

/* design/rob_pkg.sv */
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

    // what an entry does when it retires
    typedef enum logic [1:0] {
        reg_op = 2'b00,
        store  = 2'b01,
        branch = 2'b10,
        jalr   = 2'b11
    } entry_kind_t;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        logic                   busy;
        logic                   done;
        logic                   mispredict;
        entry_kind_t            kind;
        // rd in bits 4:0 for register ops, address for stores
        rv32_pkg::word_t        dest;
        // result, store data, or the pc of a branch / jalr
        rv32_pkg::word_t        value;
        rv32_pkg::word_t        target;
        rv32_pkg::store_width_t width;
    } rob_entry_t;

endpackage : rob_pkg

`default_nettype wire

/* design/store_commit_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one committing store, head of the buffer to the store unit
interface store_commit_if;

    logic                   valid;
    rv32_pkg::word_t        addr;
    rv32_pkg::word_t        data;
    rv32_pkg::store_width_t width;
    // one-cycle pulse when memory has accepted the write
    logic                   done;

    modport rob (
        output valid, addr, data, width,
        input  done
    );

    modport unit (
        input  valid, addr, data, width,
        output done
    );

endinterface : store_commit_if

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module reorder_buffer (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // dispatch, in program order
    input  wire logic                   dispatch_valid,
    input  wire rob_pkg::entry_kind_t   dispatch_kind,
    input  wire rv32_pkg::word_t        dispatch_dest,
    input  wire rv32_pkg::store_width_t dispatch_width,
    output logic                        dispatch_ready,
    output rob_pkg::rob_tag_t           dispatch_tag,
    // writeback bus, any order
    input  wire logic                   wb_valid,
    input  wire rob_pkg::rob_tag_t      wb_tag,
    input  wire rv32_pkg::word_t        wb_value,
    input  wire rv32_pkg::word_t        wb_addr,
    input  wire logic                   wb_mispredict,
    input  wire rv32_pkg::word_t        wb_target,
    // operand lookup
    input  wire rob_pkg::rob_tag_t      lookup_tag,
    output logic                        lookup_done,
    output rv32_pkg::word_t             lookup_value,
    // register file write port
    output logic                        rf_write,
    output rv32_pkg::reg_idx_t          rf_rd,
    output rv32_pkg::word_t             rf_value,
    output rob_pkg::rob_tag_t           rf_tag,
    // redirect
    output logic                        flush,
    output rv32_pkg::word_t             pc_correct,
    output logic                        br_commit,
    output logic                        br_taken_ok,
    output logic                        trap,
    store_commit_if.rob                 st
);

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];

    rob_pkg::rob_tag_t   head;
    rob_pkg::rob_tag_t   tail;
    logic [`ROB_TAG_W:0] count;

    rob_pkg::rob_entry_t head_entry;
    logic                head_ready;
    logic                is_store;
    logic                is_branch;
    logic                is_jalr;
    logic                is_reg_op;
    logic                dispatch_fire;
    logic                commit_fire;
    logic                store_retire;
    logic                retire;

    assign dispatch_ready = (count != `ROB_DEPTH);
    assign dispatch_tag   = tail;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    assign head_entry = entries[head];
    assign head_ready = head_entry.busy && head_entry.done;
    assign is_store   = (head_entry.kind == rob_pkg::store);
    assign is_branch  = (head_entry.kind == rob_pkg::branch);
    assign is_jalr    = (head_entry.kind == rob_pkg::jalr);
    assign is_reg_op  = (head_entry.kind == rob_pkg::reg_op);

    // non-store heads retire in the cycle they are seen, stores wait for memory
    assign commit_fire  = head_ready && !is_store;
    assign store_retire = st.valid && st.done;
    assign retire       = commit_fire || store_retire;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // misprediction drops every younger entry along with the head
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_fire) begin
                entries[tail].busy       <= 1'b1;
                entries[tail].done       <= 1'b0;
                entries[tail].mispredict <= 1'b0;
                entries[tail].kind       <= dispatch_kind;
                entries[tail].dest       <= dispatch_dest;
                entries[tail].width      <= dispatch_width;
                tail <= tail + 1'b1;
            end

            // stale tags from before a flush find a free entry and are dropped
            if (wb_valid && entries[wb_tag].busy) begin
                entries[wb_tag].done       <= 1'b1;
                entries[wb_tag].value      <= wb_value;
                entries[wb_tag].mispredict <= wb_mispredict;
                entries[wb_tag].target     <= wb_target;
                if (entries[wb_tag].kind == rob_pkg::store) begin
                    entries[wb_tag].dest <= wb_addr;
                end
            end

            if (retire) begin
                entries[head].busy <= 1'b0;
                entries[head].done <= 1'b0;
                head <= head + 1'b1;
            end

            case ({dispatch_fire, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // bypass from the writeback bus so a consumer sees the value a cycle early
    always_comb begin
        lookup_done  = entries[lookup_tag].busy && entries[lookup_tag].done;
        lookup_value = entries[lookup_tag].value;
        if (wb_valid && (wb_tag == lookup_tag) && entries[lookup_tag].busy) begin
            lookup_done  = 1'b1;
            lookup_value = wb_value;
        end
    end

    // jalr writes its link value as well as redirecting
    assign rf_write = head_ready && (is_reg_op || is_jalr);
    assign rf_rd    = head_entry.dest[4:0];
    assign rf_value = head_entry.value;
    assign rf_tag   = head;

    assign flush       = head_ready && (is_branch || is_jalr) && head_entry.mispredict;
    assign pc_correct  = flush ? head_entry.target : '0;
    assign br_commit   = head_ready && is_branch;
    assign br_taken_ok = br_commit && !head_entry.mispredict;

    // branch back onto itself is an endless loop
    always_comb begin
        trap = 1'b0;
        if (head_ready && is_branch && head_entry.mispredict &&
            (head_entry.target == head_entry.value)) begin
            trap = 1'b1;
        end
        if (head_ready && is_reg_op && head_entry.dest[31]) begin
            trap = 1'b1;
        end
    end

    assign st.valid = head_ready && is_store;
    assign st.addr  = head_entry.dest;
    assign st.data  = head_entry.value;
    assign st.width = head_entry.width;

endmodule : reorder_buffer

`default_nettype wire

/* design/store_commit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module store_commit (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        flush,
    store_commit_if.unit     st,
    output logic             mem_write,
    output rv32_pkg::word_t  mem_addr,
    output rv32_pkg::word_t  mem_wdata,
    output logic [3:0]       mem_byte_enable,
    input  wire logic        mem_resp
);

    typedef enum logic {
        s_idle,
        s_wait
    } state_t;

    state_t          state;
    rv32_pkg::word_t aligned_addr;
    rv32_pkg::word_t aligned_data;
    logic [3:0]      byte_en;
    rv32_pkg::word_t hold_addr;
    rv32_pkg::word_t hold_data;
    logic [3:0]      hold_be;

    always_comb begin
        aligned_addr = {st.addr[`XLEN-1:2], 2'b00};
        // move the low bytes of the data into the addressed lane
        case (st.addr[1:0])
            2'b01:   aligned_data = {st.data[23:0], st.data[31:24]};
            2'b10:   aligned_data = {st.data[15:0], st.data[31:16]};
            2'b11:   aligned_data = {st.data[7:0], st.data[31:8]};
            default: aligned_data = st.data;
        endcase
        case (st.width)
            rv32_pkg::width_byte: byte_en = 4'b0001 << st.addr[1:0];
            rv32_pkg::width_half: byte_en = st.addr[1] ? 4'b1100 : 4'b0011;
            default:              byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:  if (st.valid && !mem_resp) state <= s_wait;
                default: if (mem_resp) state <= s_idle;
            endcase
        end
    end

    // freeze the request while memory holds off
    always_ff @(posedge clk) begin
        if (state == s_idle && st.valid) begin
            hold_addr <= aligned_addr;
            hold_data <= aligned_data;
            hold_be   <= byte_en;
        end
    end

    always_comb begin
        if (state == s_wait) begin
            mem_write       = 1'b1;
            mem_addr        = hold_addr;
            mem_wdata       = hold_data;
            mem_byte_enable = hold_be;
        end else begin
            mem_write       = st.valid;
            mem_addr        = aligned_addr;
            mem_wdata       = aligned_data;
            mem_byte_enable = byte_en;
        end
    end

    assign st.done = mem_write && mem_resp;

endmodule : store_commit

`default_nettype wire

/* design/rob_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_subsystem (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   dispatch_valid,
    input  wire rob_pkg::entry_kind_t   dispatch_kind,
    input  wire rv32_pkg::word_t        dispatch_dest,
    input  wire rv32_pkg::store_width_t dispatch_width,
    output logic                        dispatch_ready,
    output rob_pkg::rob_tag_t           dispatch_tag,
    input  wire logic                   wb_valid,
    input  wire rob_pkg::rob_tag_t      wb_tag,
    input  wire rv32_pkg::word_t        wb_value,
    input  wire rv32_pkg::word_t        wb_addr,
    input  wire logic                   wb_mispredict,
    input  wire rv32_pkg::word_t        wb_target,
    input  wire rob_pkg::rob_tag_t      lookup_tag,
    output logic                        lookup_done,
    output rv32_pkg::word_t             lookup_value,
    output logic                        rf_write,
    output rv32_pkg::reg_idx_t          rf_rd,
    output rv32_pkg::word_t             rf_value,
    output rob_pkg::rob_tag_t           rf_tag,
    output logic                        mem_write,
    output rv32_pkg::word_t             mem_addr,
    output rv32_pkg::word_t             mem_wdata,
    output logic [3:0]                  mem_byte_enable,
    input  wire logic                   mem_resp,
    output logic                        flush,
    output rv32_pkg::word_t             pc_correct,
    output logic                        br_commit,
    output logic                        br_taken_ok,
    output logic                        trap
);

    store_commit_if st_bus ();

    reorder_buffer u_rob (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_kind  (dispatch_kind),
        .dispatch_dest  (dispatch_dest),
        .dispatch_width (dispatch_width),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_value       (wb_value),
        .wb_addr        (wb_addr),
        .wb_mispredict  (wb_mispredict),
        .wb_target      (wb_target),
        .lookup_tag     (lookup_tag),
        .lookup_done    (lookup_done),
        .lookup_value   (lookup_value),
        .rf_write       (rf_write),
        .rf_rd          (rf_rd),
        .rf_value       (rf_value),
        .rf_tag         (rf_tag),
        .flush          (flush),
        .pc_correct     (pc_correct),
        .br_commit      (br_commit),
        .br_taken_ok    (br_taken_ok),
        .trap           (trap),
        .st             (st_bus.rob)
    );

    // the flush also drops a store still waiting on memory
    store_commit u_store (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .st              (st_bus.unit),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_resp        (mem_resp)
    );

endmodule : rob_subsystem

`default_nettype wire

/* bench/rob_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_checker (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            dispatch_ready,
    input wire logic            rf_write,
    input wire logic            mem_write,
    input wire rv32_pkg::word_t mem_addr,
    input wire logic            mem_resp,
    input wire logic            flush
);

    // a store request stays up with the same address until memory answers
    property store_held;
        @(posedge clk) disable iff (reset)
        mem_write && !mem_resp |=> mem_write && $stable(mem_addr);
    endproperty

    // the buffer and the store unit are empty right after a flush
    property quiet_after_flush;
        @(posedge clk) disable iff (reset)
        flush |=> !rf_write && !mem_write;
    endproperty

    property ready_after_reset;
        @(posedge clk) reset |=> dispatch_ready;
    endproperty

    a_store_held: assert property (store_held)
        else $error("mem_write dropped or mem_addr moved before mem_resp");

    a_quiet_after_flush: assert property (quiet_after_flush)
        else $error("commit seen in the cycle after a flush");

    a_ready_after_reset: assert property (ready_after_reset)
        else $error("dispatch_ready low after reset");

endmodule : rob_checker

bind rob_subsystem rob_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .dispatch_ready (dispatch_ready),
    .rf_write       (rf_write),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_resp       (mem_resp),
    .flush          (flush)
);

`default_nettype wire

/* bench/rob_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_tb;

    // one expected commit; kind 0 register, 1 store, 2 branch
    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  idx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } commit_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   dispatch_valid;
    rob_pkg::entry_kind_t   dispatch_kind;
    rv32_pkg::word_t        dispatch_dest;
    rv32_pkg::store_width_t dispatch_width;
    logic                   dispatch_ready;
    rob_pkg::rob_tag_t      dispatch_tag;
    logic                   wb_valid;
    rob_pkg::rob_tag_t      wb_tag;
    rv32_pkg::word_t        wb_value;
    rv32_pkg::word_t        wb_addr;
    logic                   wb_mispredict;
    rv32_pkg::word_t        wb_target;
    rob_pkg::rob_tag_t      lookup_tag;
    logic                   lookup_done;
    rv32_pkg::word_t        lookup_value;
    logic                   rf_write;
    rv32_pkg::reg_idx_t     rf_rd;
    rv32_pkg::word_t        rf_value;
    rob_pkg::rob_tag_t      rf_tag;
    logic                   mem_write;
    rv32_pkg::word_t        mem_addr;
    rv32_pkg::word_t        mem_wdata;
    logic [3:0]             mem_byte_enable;
    logic                   mem_resp = 1'b0;
    logic                   flush;
    rv32_pkg::word_t        pc_correct;
    logic                   br_commit;
    logic                   br_taken_ok;
    logic                   trap;

    string             lines [$];
    commit_t           expected [$];
    rob_pkg::rob_tag_t tag_of [64];
    int                resp_delay [64];
    string             test_name = "reset";
    int                dispatched = 0;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                cycle_limit = 0;
    int                resp_wait = 0;
    int                store_count = 0;
    logic              mem_busy = 1'b0;

    rob_subsystem DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // memory answers each write after a random delay
    always @(posedge clk) begin
        if (reset) begin
            mem_resp <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (resp_wait <= 1) begin
                mem_resp <= 1'b1;
            end
            resp_wait <= resp_wait - 1;
        end else if (mem_write) begin
            if (resp_delay[store_count % 64] == 0) begin
                mem_resp <= 1'b1;
            end else begin
                mem_busy  <= 1'b1;
                resp_wait <= resp_delay[store_count % 64];
            end
            store_count <= store_count + 1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // store data moves up by one byte lane per address offset
    function automatic logic [31:0] lane_data(input logic [31:0] data, input logic [1:0] off);
        logic [63:0] twice;
        twice = {data, data};
        return twice[63 - 8 * off -: 32];
    endfunction

    function automatic logic [3:0] lane_enables(input logic [1:0] width, input logic [1:0] off);
        int         bytes;
        int         first;
        logic [3:0] en;
        case (width)
            2'd0:    bytes = 1;
            2'd1:    bytes = 2;
            default: bytes = 4;
        endcase
        // the access covers its own size, aligned within the word
        first = int'(off) / bytes * bytes;
        en    = '0;
        for (int lane = 0; lane < 4; lane++) begin
            if (lane >= first && lane < first + bytes) begin
                en[lane] = 1'b1;
            end
        end
        return en;
    endfunction

    task automatic compare_commit();
        commit_t e;
        if (expected.size() == 0) begin
            errors++;
            $display("%s: a commit appeared that no test line expects", test_name);
            return;
        end
        e = expected.pop_front();
        case (e.kind)
            2'd0: begin
                check_value("rf_write", 1, rf_write);
                check_value("rf_rd", e.a, rf_rd);
                check_value("rf_value", e.b, rf_value);
                check_value("rf_tag", tag_of[e.idx], rf_tag);
                check_value("trap", e.c, trap);
            end
            2'd1: begin
                check_value("store done", 1, mem_write && mem_resp);
                check_value("mem_addr", e.a & 32'hffff_fffc, mem_addr);
                check_value("mem_wdata", lane_data(e.b, e.a[1:0]), mem_wdata);
                check_value("mem_byte_enable", lane_enables(e.c[1:0], e.a[1:0]),
                            mem_byte_enable);
            end
            default: begin
                check_value("br_commit", 1, br_commit);
                check_value("flush", e.a, flush);
                check_value("br_taken_ok", !e.a[0], br_taken_ok);
                if (e.a[0]) begin
                    check_value("pc_correct", e.b, pc_correct);
                end
                check_value("trap", e.c, trap);
            end
        endcase
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && (rf_write || br_commit || flush || (mem_write && mem_resp))) begin
            compare_commit();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        dispatch_valid <= 1'b0;
        wb_valid       <= 1'b0;
    endtask

    task automatic drain();
        while (expected.size() != 0) begin
            next_cycle();
            @(negedge clk);
        end
        repeat (2) begin
            next_cycle();
            @(negedge clk);
        end
    endtask

    task automatic run_line(input string line);
        string             op;
        string             typ;
        int                idx;
        int                kind;
        int                flag;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       c;
        logic [31:0]       d;
        commit_t           e;
        rob_pkg::rob_tag_t held_tag;
        rob_pkg::rob_tag_t next_tag;
        void'($sscanf(line, "%s", op));
        if (op == "T") begin
            drain();
            void'($sscanf(line, "%s %s", op, test_name));
            dispatched = 0;
        end else if (op == "E") begin
            void'($sscanf(line, "%s %s %d %h %h %h", op, typ, idx, a, b, c));
            e.kind = (typ == "r") ? 2'd0 : (typ == "s") ? 2'd1 : 2'd2;
            e.idx  = idx[7:0];
            e.a    = a;
            e.b    = b;
            e.c    = c;
            expected.push_back(e);
        end else if (op == "D") begin
            void'($sscanf(line, "%s %d %h %d", op, kind, a, flag));
            next_cycle();
            dispatch_valid <= 1'b1;
            dispatch_kind  <= rob_pkg::entry_kind_t'(kind);
            dispatch_dest  <= a;
            dispatch_width <= rv32_pkg::store_width_t'(flag);
            @(negedge clk);
            while (!dispatch_ready) begin
                @(negedge clk);
            end
            tag_of[dispatched] = dispatch_tag;
            // tags go around the buffer one entry per dispatch
            if (dispatched > 0) begin
                next_tag = tag_of[dispatched - 1] + 1'b1;
                check_value("dispatch_tag", next_tag, dispatch_tag);
            end
            dispatched++;
        end else if (op == "W" || op == "Y") begin
            void'($sscanf(line, "%s %d %h %h %d %h", op, idx, a, b, flag, d));
            if (op == "Y") begin
                b    = '0;
                flag = 0;
                d    = '0;
            end
            next_cycle();
            wb_valid      <= 1'b1;
            wb_tag        <= tag_of[idx];
            wb_value      <= a;
            wb_addr       <= b;
            wb_mispredict <= flag[0];
            wb_target     <= d;
            lookup_tag    <= tag_of[idx];
            @(negedge clk);
            if (op == "Y") begin
                check_value("bypass lookup_done", 1, lookup_done);
                check_value("bypass lookup_value", a, lookup_value);
            end
        end else if (op == "L") begin
            void'($sscanf(line, "%s %d %d %h", op, idx, flag, a));
            next_cycle();
            lookup_tag <= tag_of[idx];
            @(negedge clk);
            check_value("lookup_done", flag, lookup_done);
            if (flag != 0) begin
                check_value("lookup_value", a, lookup_value);
            end
        end else if (op == "R") begin
            void'($sscanf(line, "%s %d", op, flag));
            next_cycle();
            @(negedge clk);
            check_value("dispatch_ready", flag, dispatch_ready);
        end else if (op == "H") begin
            // dispatch against a full buffer must not allocate
            next_cycle();
            dispatch_valid <= 1'b1;
            dispatch_kind  <= rob_pkg::reg_op;
            dispatch_dest  <= '0;
            @(negedge clk);
            held_tag = dispatch_tag;
            check_value("held dispatch_ready", 0, dispatch_ready);
            @(negedge clk);
            check_value("held dispatch_tag", held_tag, dispatch_tag);
        end else if (op == "I") begin
            void'($sscanf(line, "%s %d", op, flag));
            repeat (flag) begin
                next_cycle();
                @(negedge clk);
            end
        end else begin
            errors++;
            $display("unrecognized line in the tests file: %s", line);
        end
    endtask

    initial begin
        int    fd;
        string line;
        void'($urandom(32'hee1f));
        foreach (resp_delay[i]) begin
            resp_delay[i] = $urandom % 5;
        end
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_kind  = rob_pkg::reg_op;
        dispatch_dest  = '0;
        dispatch_width = rv32_pkg::width_word;
        wb_valid       = 1'b0;
        wb_tag         = '0;
        wb_value       = '0;
        wb_addr        = '0;
        wb_mispredict  = 1'b0;
        wb_target      = '0;
        lookup_tag     = '0;

        fd = $fopen("bench/rob_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bench/rob_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 8 + 20;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        drain();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : rob_tb

`default_nettype wire

/* list.f */
+incdir+design
design/rv32_pkg.sv
design/rob_pkg.sv
design/store_commit_if.sv
design/reorder_buffer.sv
design/store_commit.sv
design/rob_subsystem.sv
bench/rob_checker.sv
bench/rob_tb.sv

/* bench/rob_tests.txt */
# D kind dest width | W idx value addr mispredict target | Y idx value | L idx done value
# E type(r/s/b) idx a b c : r rd value trap, s addr data width, b mispredict target trap
# R ready | H held dispatch | I cycles | T name ; idx counts dispatches within a test
T full_buffer
E r 0 01 00000101 0
E r 1 02 00000102 0
E r 2 03 00000103 0
E r 3 04 00000104 0
E r 4 05 00000105 0
E r 5 06 00000106 0
E r 6 07 00000107 0
E r 7 08 00000108 0
D 0 00000001 2
D 0 00000002 2
D 0 00000003 2
D 0 00000004 2
D 0 00000005 2
D 0 00000006 2
D 0 00000007 2
D 0 00000008 2
R 0
H
W 0 00000101 00000000 0 00000000
I 1
R 1
W 7 00000108 00000000 0 00000000
W 6 00000107 00000000 0 00000000
W 5 00000106 00000000 0 00000000
W 4 00000105 00000000 0 00000000
W 3 00000104 00000000 0 00000000
W 2 00000103 00000000 0 00000000
W 1 00000102 00000000 0 00000000
T store_align
E s 0 00000101 000000a5 0
E s 1 00000103 0000007e 0
E s 2 00000200 0000beef 1
E s 3 00000202 0000cafe 1
E s 4 00000300 12345678 2
E r 5 0a 00000abc 0
D 1 00000000 0
D 1 00000000 0
D 1 00000000 1
D 1 00000000 1
D 1 00000000 2
D 0 0000000a 0
W 5 00000abc 00000000 0 00000000
W 3 0000cafe 00000202 0 00000000
W 4 12345678 00000300 0 00000000
W 1 0000007e 00000103 0 00000000
W 2 0000beef 00000200 0 00000000
W 0 000000a5 00000101 0 00000000
T mispredict
E b 0 1 00000400 0
D 2 00000000 0
D 0 00000005 0
W 1 00000055 00000000 0 00000000
W 0 00000100 00000000 1 00000400
T branch_ok
E b 0 0 00000000 0
E r 1 06 00000066 0
D 2 00000000 0
D 0 00000006 0
W 0 00000180 00000000 0 00000200
W 1 00000066 00000000 0 00000000
T lookup
E r 0 07 00000077 0
E r 1 08 00000088 0
D 0 00000007 0
D 0 00000008 0
L 1 0 00000000
Y 1 00000088
L 1 1 00000088
W 0 00000077 00000000 0 00000000
T self_loop
E b 0 1 00000300 1
D 2 00000000 0
W 0 00000300 00000000 1 00000300
